/* verilog/sgd_pkg.sv */
/*
 * shared widths and typedefs for the fixed point sgd core
 * config, sample and per-stage pipeline structs
 * model and gradient vectors
 * write-back state encoding
 */

package sgd_pkg;

	// model size
	localparam int NUM_FEATURES  = 4;
	// default fraction bits of the weights
	localparam int FRAC_BITS_DEF = 8;

	// scalar widths
	typedef logic signed [15:0] feature_t;
	typedef logic signed [15:0] label_t;
	typedef logic signed [15:0] weight_t;
	typedef logic signed [31:0] dot_t;
	typedef logic signed [31:0] err_t;
	typedef logic signed [47:0] acc_t;
	typedef logic [1:0]         feat_idx_t;
	typedef logic [4:0]         shift_t;
	typedef logic [7:0]         count_t;

	// run config, latched on start
	typedef struct packed {
		count_t batch_size;
		count_t num_batches;
		shift_t step_shift;
	} sgd_cfg_t;

	typedef struct packed {
		feature_t [NUM_FEATURES-1:0] features;
		label_t                      label;
		logic                        last;
	} sample_t;

	// dot product stage output
	typedef struct packed {
		dot_t                        dot;
		feature_t [NUM_FEATURES-1:0] features;
		label_t                      label;
		logic                        last;
	} dot_item_t;

	// loss stage output, label no longer needed
	typedef struct packed {
		err_t                        err;
		feature_t [NUM_FEATURES-1:0] features;
		logic                        last;
	} err_item_t;

	typedef weight_t [NUM_FEATURES-1:0] model_t;
	typedef acc_t [NUM_FEATURES-1:0]    grad_vec_t;

	typedef enum logic [1:0] {
		WB_IDLE = 2'd0,
		WB_SEND = 2'd1,
		WB_DONE = 2'd2
	} wb_state_t;

endpackage

/* verilog/sgd_dot_product.sv */
/*
 * input stage of the sgd core
 * batch sample counter, last tagging and the raw hazard stall
 * two stage multiply and sum against the current model
 */

`timescale 1ns/1ps

module sgd_dot_product (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  sgd_pkg::count_t     cfg_batch_size,
	input  logic                sample_wr_en,
	input  sgd_pkg::sample_t    sample,
	input  sgd_pkg::model_t     model,
	input  logic                update_done,
	output logic                sample_full,
	output logic                dot_valid,
	output sgd_pkg::dot_item_t  dot_item
);
	import sgd_pkg::*;

	count_t                      sample_cnt;
	logic                        take;
	logic                        is_last;
	// product stage
	logic                        prod_valid;
	dot_t [NUM_FEATURES-1:0]     prod_q;
	feature_t [NUM_FEATURES-1:0] feat_q;
	label_t                      label_q;
	logic                        last_q;
	dot_t                        prod_sum;

	//////////////////////////////////////////////////
	// batch tracking and stall
	//////////////////////////////////////////////////
	assign take    = sample_wr_en && !sample_full;
	// batch end comes from the count, the source flag is replaced
	assign is_last = (sample_cnt == count_t'(cfg_batch_size - 8'd1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt  <= '0;
			// closed until the first start
			sample_full <= 1'b1;
		end else if (start) begin
			sample_cnt  <= '0;
			sample_full <= 1'b0;
		end else begin
			if (take) begin
				sample_cnt <= is_last ? '0 : count_t'(sample_cnt + 8'd1);
			end
			// hold off the next batch until the model is rewritten
			if (take && is_last) begin
				sample_full <= 1'b1;
			end else if (update_done) begin
				sample_full <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// multiply, then sum
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			dot_valid  <= 1'b0;
		end else begin
			prod_valid <= take;
			dot_valid  <= prod_valid;
		end
	end

	// payload regs
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_FEATURES; i++) begin
			prod_q[i] <= $signed(sample.features[i]) * $signed(model[i]);
		end
		feat_q            <= sample.features;
		label_q           <= sample.label;
		last_q            <= is_last;
		dot_item.dot      <= prod_sum;
		dot_item.features <= feat_q;
		dot_item.label    <= label_q;
		dot_item.last     <= last_q;
	end

	// adder tree, wraps at 32 bits
	always_comb begin
		prod_sum = '0;
		for (int i = 0; i < NUM_FEATURES; i++) begin
			prod_sum = prod_sum + prod_q[i];
		end
	end

	// source honours the stall
	a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(sample_wr_en && sample_full));

endmodule

/* verilog/sgd_loss.sv */
/*
 * loss stage of the sgd core
 * scaled label subtract and arithmetic step shift
 */

`timescale 1ns/1ps

module sgd_loss #(
	parameter int FRAC_BITS = sgd_pkg::FRAC_BITS_DEF
) (
	input  logic                clk,
	input  logic                rst_n,
	input  sgd_pkg::shift_t     step_shift,
	input  logic                dot_valid,
	input  sgd_pkg::dot_item_t  dot_item,
	output logic                err_valid,
	output sgd_pkg::err_item_t  err_item
);
	import sgd_pkg::*;

	// one guard bit so the subtract itself cannot wrap
	logic signed [32:0] label_ext;
	logic signed [32:0] diff;
	logic signed [32:0] diff_sh;

	always_comb begin
		// label moved to the weight fraction point
		label_ext = 33'($signed(dot_item.label)) <<< FRAC_BITS;
		diff      = 33'($signed(dot_item.dot)) - label_ext;
		diff_sh   = diff >>> step_shift;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_valid <= 1'b0;
		end else begin
			err_valid <= dot_valid;
		end
	end

	always_ff @(posedge clk) begin
		err_item.err      <= err_t'(diff_sh[31:0]);
		err_item.features <= dot_item.features;
		err_item.last     <= dot_item.last;
	end

endmodule

/* verilog/sgd_gradient.sv */
/*
 * gradient stage of the sgd core
 * error times feature products
 * per weight batch accumulators, flushed on the last sample
 */

`timescale 1ns/1ps

module sgd_gradient (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                err_valid,
	input  sgd_pkg::err_item_t  err_item,
	output logic                grad_valid,
	output sgd_pkg::grad_vec_t  grad
);
	import sgd_pkg::*;

	logic      prod_valid;
	logic      prod_last;
	grad_vec_t prod_q;
	grad_vec_t acc_q;

	//////////////////////////////////////////////////
	// products, 32x16 into 48
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_FEATURES; i++) begin
			prod_q[i] <= $signed(err_item.err) * $signed(err_item.features[i]);
		end
		prod_last <= err_item.last;
	end

	//////////////////////////////////////////////////
	// accumulate
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			grad_valid <= 1'b0;
			acc_q      <= '0;
		end else begin
			prod_valid <= err_valid && !start;
			grad_valid <= prod_valid && prod_last && !start;
			if (start) begin
				acc_q <= '0;
			end else if (prod_valid) begin
				for (int i = 0; i < NUM_FEATURES; i++) begin
					// batch end clears, otherwise wrap at 48 bits
					acc_q[i] <= prod_last ? '0 : acc_t'(acc_q[i] + prod_q[i]);
				end
			end
		end
	end

	// completed batch sums, including the last product
	always_ff @(posedge clk) begin
		if (prod_valid && prod_last) begin
			for (int i = 0; i < NUM_FEATURES; i++) begin
				grad[i] <= acc_q[i] + prod_q[i];
			end
		end
	end

	// batches are at least one sample apart
	a_grad_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		grad_valid |=> !grad_valid);

endmodule

/* verilog/sgd_model_update.sv */
/*
 * model stage of the sgd core
 * weight registers and batch update
 * batch counter, stall release and end of run pulse
 */

`timescale 1ns/1ps

module sgd_model_update #(
	parameter int FRAC_BITS = sgd_pkg::FRAC_BITS_DEF
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  sgd_pkg::count_t     cfg_num_batches,
	input  logic                grad_valid,
	input  sgd_pkg::grad_vec_t  grad,
	output sgd_pkg::model_t     model,
	output logic                update_done,
	output logic                run_done
);
	import sgd_pkg::*;

	count_t    batch_cnt;
	logic      is_final;
	grad_vec_t grad_sh;
	model_t    next_model;

	//////////////////////////////////////////////////
	// update arithmetic
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < NUM_FEATURES; i++) begin
			// back to the weight fraction point
			grad_sh[i]    = $signed(grad[i]) >>> FRAC_BITS;
			// low 16 bits only, wraps like the weight
			next_model[i] = model[i] - weight_t'(grad_sh[i][15:0]);
		end
	end

	assign is_final = (batch_cnt == count_t'(cfg_num_batches - 8'd1));

	//////////////////////////////////////////////////
	// weights and batch count
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			model       <= '0;
			batch_cnt   <= '0;
			update_done <= 1'b0;
			run_done    <= 1'b0;
		end else if (start) begin
			// every run begins from a zero model
			model       <= '0;
			batch_cnt   <= '0;
			update_done <= 1'b0;
			run_done    <= 1'b0;
		end else begin
			update_done <= grad_valid && !is_final;
			run_done    <= grad_valid && is_final;
			if (grad_valid) begin
				model     <= next_model;
				batch_cnt <= is_final ? '0 : count_t'(batch_cnt + 8'd1);
			end
		end
	end

endmodule

/* verilog/sgd_writeback.sv */
/*
 * write-back stage of the sgd core
 * streams the final weights one index per cycle
 * waits while the sink reports almost full
 */

`timescale 1ns/1ps

module sgd_writeback (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                run_done,
	input  sgd_pkg::model_t     model,
	input  logic                x_out_almost_full,
	output logic                x_out_valid,
	output sgd_pkg::feat_idx_t  x_out_index,
	output sgd_pkg::weight_t    x_out_data,
	output logic                done
);
	import sgd_pkg::*;

	localparam feat_idx_t LAST_IDX = feat_idx_t'(NUM_FEATURES - 1);

	wb_state_t state_q;
	feat_idx_t idx_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= WB_IDLE;
			idx_q   <= '0;
		end else if (start) begin
			state_q <= WB_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				WB_IDLE: begin
					if (run_done) begin
						state_q <= WB_SEND;
					end
				end
				WB_SEND: begin
					// sink full, hold index
					if (!x_out_almost_full) begin
						idx_q <= (idx_q == LAST_IDX) ? '0 : feat_idx_t'(idx_q + 2'd1);
						if (idx_q == LAST_IDX) begin
							state_q <= WB_DONE;
						end
					end
				end
				// parked until the next start
				default: state_q <= WB_DONE;
			endcase
		end
	end

	assign x_out_valid = (state_q == WB_SEND) && !x_out_almost_full;
	assign x_out_index = idx_q;
	assign x_out_data  = model[idx_q];
	assign done        = (state_q == WB_DONE);

	// one end of run per start
	a_run_done_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		run_done |-> (state_q == WB_IDLE));

endmodule

/* verilog/sgd_top.sv */
/*
 * top level of the single engine sgd core
 * config latch and the five stage pipeline
 */

`timescale 1ns/1ps

module sgd_top #(
	parameter int FRAC_BITS = sgd_pkg::FRAC_BITS_DEF
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  sgd_pkg::sgd_cfg_t   cfg,
	input  logic                sample_wr_en,
	input  sgd_pkg::sample_t    sample,
	input  logic                x_out_almost_full,
	output logic                sample_full,
	output logic                x_out_valid,
	output sgd_pkg::feat_idx_t  x_out_index,
	output sgd_pkg::weight_t    x_out_data,
	output logic                done
);
	import sgd_pkg::*;

	sgd_cfg_t  cfg_q;
	// stage to stage
	logic      dot_valid;
	dot_item_t dot_item;
	logic      err_valid;
	err_item_t err_item;
	logic      grad_valid;
	grad_vec_t grad;
	model_t    model;
	logic      update_done;
	logic      run_done;

	//////////////////////////////////////////////////
	// config held for the whole run
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else if (start) begin
			cfg_q <= cfg;
		end
	end

	sgd_dot_product u_dot (
		.clk(clk), .rst_n(rst_n), .start(start),
		.cfg_batch_size(cfg_q.batch_size),
		.sample_wr_en(sample_wr_en), .sample(sample),
		.model(model), .update_done(update_done),
		.sample_full(sample_full), .dot_valid(dot_valid), .dot_item(dot_item)
	);

	sgd_loss #(.FRAC_BITS(FRAC_BITS)) u_loss (
		.clk(clk), .rst_n(rst_n), .step_shift(cfg_q.step_shift),
		.dot_valid(dot_valid), .dot_item(dot_item),
		.err_valid(err_valid), .err_item(err_item)
	);

	sgd_gradient u_grad (
		.clk(clk), .rst_n(rst_n), .start(start),
		.err_valid(err_valid), .err_item(err_item),
		.grad_valid(grad_valid), .grad(grad)
	);

	sgd_model_update #(.FRAC_BITS(FRAC_BITS)) u_model (
		.clk(clk), .rst_n(rst_n), .start(start),
		.cfg_num_batches(cfg_q.num_batches),
		.grad_valid(grad_valid), .grad(grad),
		.model(model), .update_done(update_done), .run_done(run_done)
	);

	// final weights out
	sgd_writeback u_wb (
		.clk(clk), .rst_n(rst_n), .start(start), .run_done(run_done),
		.model(model), .x_out_almost_full(x_out_almost_full),
		.x_out_valid(x_out_valid), .x_out_index(x_out_index),
		.x_out_data(x_out_data), .done(done)
	);

endmodule

/* testbench/tb_sgd_top.sv */
/*
 * testbench for the sgd core
 * clock, reset and case file stimulus
 * reference weight model and compare tasks
 * random almost full on the weight output
 */

`timescale 1ns/1ps

module tb_sgd_top;
	import sgd_pkg::*;

	localparam int FRAC_BITS   = 8;
	localparam int WAIT_CYCLES = 200;

	logic      clk;
	logic      rst_n;
	logic      start;
	sgd_cfg_t  cfg;
	logic      sample_wr_en;
	sample_t   sample;
	logic      x_out_almost_full;
	logic      sample_full;
	logic      x_out_valid;
	feat_idx_t x_out_index;
	weight_t   x_out_data;
	logic      done;

	logic [15:0] cases_mem [0:255];
	logic [31:0] lfsr;
	int          errors;
	int          tests;
	int          failed;
	logic        timed_out;
	model_t      ref_model;
	model_t      file_model;

	sgd_top #(.FRAC_BITS(FRAC_BITS)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_weight(input feat_idx_t got_idx, input feat_idx_t exp_idx,
		input weight_t got, input weight_t exp);
		if (got_idx !== exp_idx) begin
			$display("ERR x_out_index got %h expected %h", got_idx, exp_idx);
			errors++;
		end
		if (got !== exp) begin
			$display("ERR x_out_data[%0d] got %h expected %h", exp_idx, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// sample source
	//////////////////////////////////////////////////
	// entered and left 2 ns after a rising edge
	task automatic write_sample(input sample_t s);
		int n;
		n = 0;
		while (sample_full && n < WAIT_CYCLES && !timed_out) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (sample_full) begin
			if (!timed_out) begin
				$display("timeout while waiting for sample_full to fall");
				errors++;
			end
			timed_out = 1'b1;
		end else begin
			sample_wr_en = 1'b1;
			sample       = s;
			@(posedge clk);
			#2;
			sample_wr_en = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////
	// one case from the file
	//////////////////////////////////////////////////
	task automatic run_case(inout int ptr);
		sgd_cfg_t           c;
		logic               bp;
		sample_t            s;
		acc_t               acc [NUM_FEATURES];
		logic signed [63:0] dot64;
		logic signed [63:0] f64;
		logic signed [63:0] t64;
		err_t               err;
		int                 words;
		int                 n;
		int                 errs_before;
		c.batch_size  = count_t'(cases_mem[ptr]);
		c.num_batches = count_t'(cases_mem[ptr+1]);
		c.step_shift  = shift_t'(cases_mem[ptr+2]);
		bp            = cases_mem[ptr+3][0];
		ptr           = ptr + 4;
		errs_before   = errors;
		// start also restarts a finished run
		cfg   = c;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		check_flag("done", done, 1'b0);
		check_flag("sample_full", sample_full, 1'b0);
		ref_model = '0;
		for (int b = 0; b < c.num_batches; b++) begin
			for (int i = 0; i < NUM_FEATURES; i++) begin
				acc[i] = '0;
			end
			for (int k = 0; k < c.batch_size; k++) begin
				for (int i = 0; i < NUM_FEATURES; i++) begin
					s.features[i] = feature_t'(cases_mem[ptr+i]);
				end
				s.label = label_t'(cases_mem[ptr+NUM_FEATURES]);
				s.last  = (k == c.batch_size - 1);
				ptr     = ptr + NUM_FEATURES + 1;
				// dot against the model of this batch
				dot64 = '0;
				for (int i = 0; i < NUM_FEATURES; i++) begin
					f64   = $signed(s.features[i]);
					t64   = $signed(ref_model[i]);
					dot64 = dot64 + f64 * t64;
				end
				t64 = $signed(dot64[31:0]);
				f64 = $signed(s.label);
				t64 = (t64 - (f64 <<< FRAC_BITS)) >>> c.step_shift;
				err = t64[31:0];
				for (int i = 0; i < NUM_FEATURES; i++) begin
					f64    = $signed(s.features[i]);
					t64    = $signed(err);
					t64    = $signed(acc[i]) + t64 * f64;
					acc[i] = t64[47:0];
				end
				write_sample(s);
			end
			// batch end update
			for (int i = 0; i < NUM_FEATURES; i++) begin
				t64          = $signed(acc[i]);
				t64          = t64 >>> FRAC_BITS;
				ref_model[i] = ref_model[i] - t64[15:0];
			end
		end
		for (int i = 0; i < NUM_FEATURES; i++) begin
			file_model[i] = weight_t'(cases_mem[ptr+i]);
		end
		ptr = ptr + NUM_FEATURES;
		if (file_model !== ref_model) begin
			$display("weights in the case file differ from the reference model");
			errors++;
		end
		// collect the write-back words
		words = 0;
		n     = 0;
		while (!done && n < WAIT_CYCLES && !timed_out) begin
			x_out_almost_full = bp ? lfsr[0] : 1'b0;
			if (bp) begin
				lfsr = lfsr_next(lfsr);
			end
			#8;
			if (x_out_valid) begin
				check_flag("x_out_almost_full", x_out_almost_full, 1'b0);
				check_flag("done", done, 1'b0);
				if (words < NUM_FEATURES) begin
					check_weight(x_out_index, feat_idx_t'(words), x_out_data,
						file_model[words]);
				end
				words++;
			end
			@(posedge clk);
			#2;
			n++;
		end
		x_out_almost_full = 1'b0;
		if (!done && !timed_out) begin
			$display("timeout while waiting for done");
			errors++;
			timed_out = 1'b1;
		end
		if (words != NUM_FEATURES) begin
			$display("write-back sent %0d words instead of %0d", words, NUM_FEATURES);
			errors++;
		end
		// stall held after the final batch
		check_flag("sample_full", sample_full, 1'b1);
		tests++;
		if (errors != errs_before) begin
			failed++;
		end
		$display("case %0d batch %0d x %0d shift %0d bp %0d %s", tests - 1, c.batch_size,
			c.num_batches, c.step_shift, bp, (errors == errs_before) ? "ok" : "FAIL");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int ptr;
		int ncases;
		rst_n             = 1'b0;
		start             = 1'b0;
		cfg               = '0;
		sample_wr_en      = 1'b0;
		sample            = '0;
		x_out_almost_full = 1'b0;
		errors            = 0;
		tests             = 0;
		failed            = 0;
		timed_out         = 1'b0;
		lfsr              = 32'had19;
		ptr               = 0;
		ncases            = 0;
		$readmemh("testbench/sgd_cases.txt", cases_mem);
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		// idle state before the first start
		check_flag("sample_full", sample_full, 1'b1);
		check_flag("x_out_valid", x_out_valid, 1'b0);
		check_flag("done", done, 1'b0);
		tests++;
		if (errors != 0) begin
			failed++;
		end
		$display("reset state %s", (errors == 0) ? "ok" : "FAIL");
		while (ptr < 240 && cases_mem[ptr] != 16'h0 && !timed_out) begin
			run_case(ptr);
			ncases++;
		end
		if (ncases == 0) begin
			$display("no test cases were read from the case file");
			errors++;
		end
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* testbench/sgd_cases.txt */
// per case: batch_size num_batches step_shift backpressure, then per sample f0 f1 f2 f3 label,
// then the four expected weights in Q8; a batch_size of 0 ends the list
// single batch of one sample
0001 0001 0000 0000
0001 0002 0000 0000 0001
0001 0002 0000 0000
// two batches of two, step shift 2, random almost full
0002 0002 0002 0001
0001 0000 0000 0000 0002
0000 0001 0000 0000 0004
0002 0000 0000 0000 0001
0000 0000 0003 0000 ffff
0002 0001 0000 0000
// restart with one batch of three
0003 0001 0000 0001
0001 0001 0001 0001 0001
0000 0000 0002 0000 0000
0000 0000 0000 ffff 0002
0001 0001 0001 ffff
// end of list
0000

/* project.f */
verilog/sgd_pkg.sv
verilog/sgd_dot_product.sv
verilog/sgd_loss.sv
verilog/sgd_gradient.sv
verilog/sgd_model_update.sv
verilog/sgd_writeback.sv
verilog/sgd_top.sv
testbench/tb_sgd_top.sv

/* Makefile */
# verilator build and run of the sgd core testbench

all: run

obj_dir/Vtb_sgd_top: project.f $(wildcard verilog/*.sv testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_sgd_top -f project.f -o Vtb_sgd_top

run: obj_dir/Vtb_sgd_top
	./obj_dir/Vtb_sgd_top | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing --top-module sgd_top -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
